// ==== filelist.f ====
source/ps_axi_pkg.sv
source/ps_req_if.sv
source/ps_mem_if.sv
source/axi_lite_receiver.sv
source/ps_reqhandler.sv
source/ps_reg_bank.sv
source/ps_axi_top.sv
verif/tb_ps_axi.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_ps_axi -o sim_tb && \
./obj_dir/sim_tb | tee /dev/stderr | grep -F -q '*** PASSED ***' && \
echo "Simulation passed" || { echo "Simulation did not pass"; exit 1; }

// ==== source/axi_lite_receiver.sv ====
`timescale 1ns/100ps

module axi_lite_receiver #(
	parameter int MEM_DEPTH = 64,
	parameter int REQ_BUFFER_SZ = 4
) (
	input logic clk,
	input logic rst,
	input logic awvalid,
	output logic awready,
	input ps_axi_pkg::index_t awaddr,
	input logic wvalid,
	output logic wready,
	input ps_axi_pkg::data_t wdata,
	input logic arvalid,
	output logic arready,
	input ps_axi_pkg::index_t araddr,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	output ps_axi_pkg::index_t bank_raddr,
	input ps_axi_pkg::data_t bank_rdata,
	ps_req_if.rx req
);
	import ps_axi_pkg::*;

	typedef logic [$clog2(REQ_BUFFER_SZ):0] cnt_t;

	cnt_t aw_cnt, w_cnt, ar_cnt; // Accepted but not yet answered
	logic aw_hs, w_hs, ar_hs, b_hs, r_hs;
	logic ar_pend; // Bank read in flight
	index_t ar_index;
	logic ar_in_range;

	function automatic cnt_t next_cnt(cnt_t cnt, logic inc, logic dec);
		return cnt + cnt_t'(inc) - cnt_t'(dec);
	endfunction

	assign awready = (aw_cnt != cnt_t'(REQ_BUFFER_SZ));
	assign wready = (w_cnt != cnt_t'(REQ_BUFFER_SZ));
	assign arready = (ar_cnt != cnt_t'(REQ_BUFFER_SZ));

	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;
	assign ar_hs = arvalid && arready;
	assign b_hs = bvalid && bready;
	assign r_hs = rvalid && rready;

	assign bank_raddr = araddr; // Bank samples the index on the AR edge

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_cnt <= '0;
			w_cnt <= '0;
			ar_cnt <= '0;
			ar_pend <= 1'b0;
			req.have_windex <= 1'b0;
			req.have_wdata <= 1'b0;
			req.have_rdata <= 1'b0;
		end else begin
			aw_cnt <= next_cnt(aw_cnt, aw_hs, b_hs);
			w_cnt <= next_cnt(w_cnt, w_hs, b_hs);
			ar_cnt <= next_cnt(ar_cnt, ar_hs, r_hs);
			req.have_windex <= aw_hs;
			req.have_wdata <= w_hs;
			ar_pend <= ar_hs;
			req.have_rdata <= ar_pend; // Bank word is valid one cycle after AR
		end
	end

	// Payload stages
	always_ff @(posedge clk) begin
		if (aw_hs) req.windex <= awaddr;
		if (w_hs) req.wdata <= wdata;
		if (ar_hs) begin
			ar_index <= araddr;
			ar_in_range <= (araddr < MEM_DEPTH);
		end
		if (ar_pend) begin
			req.rindex <= ar_index;
			req.rdata <= ar_in_range ? bank_rdata : '0; // Unimplemented words read as zero
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		aw_cnt <= REQ_BUFFER_SZ && w_cnt <= REQ_BUFFER_SZ && ar_cnt <= REQ_BUFFER_SZ);

	// A response must never come back without an accepted request behind it
	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		(b_hs |-> (aw_cnt != 0 && w_cnt != 0)) and (r_hs |-> ar_cnt != 0));
endmodule

// ==== source/ps_axi_pkg.sv ====
package ps_axi_pkg;

	// Bus widths
	localparam int DATA_W = 32;
	localparam int INDEX_W = 8; // Address is a word index

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [1:0] resp_t;

	// AXI response codes
	localparam resp_t OKAY = 2'b00;
	localparam resp_t SLVERR = 2'b10;

endpackage

// ==== source/ps_axi_top.sv ====
`timescale 1ns/100ps

module ps_axi_top #(
	parameter int MEM_DEPTH = 64,
	parameter int REQ_BUFFER_SZ = 4
) (
	input logic clk,
	input logic rst,
	input logic awvalid,
	output logic awready,
	input ps_axi_pkg::index_t awaddr,
	input logic wvalid,
	output logic wready,
	input ps_axi_pkg::data_t wdata,
	output logic bvalid,
	input logic bready,
	output ps_axi_pkg::resp_t bresp,
	input logic arvalid,
	output logic arready,
	input ps_axi_pkg::index_t araddr,
	output logic rvalid,
	input logic rready,
	output ps_axi_pkg::data_t rdata,
	output ps_axi_pkg::resp_t rresp
);
	import ps_axi_pkg::*;

	index_t bank_raddr;
	data_t bank_rdata;

	ps_req_if req_if ();
	ps_mem_if mem_if ();

	assign rresp = OKAY; // Reads never fail

	axi_lite_receiver #(
		.MEM_DEPTH(MEM_DEPTH),
		.REQ_BUFFER_SZ(REQ_BUFFER_SZ)
	) u_rx (
		.clk(clk),
		.rst(rst),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.bvalid(bvalid),
		.bready(bready),
		.rvalid(rvalid),
		.rready(rready),
		.bank_raddr(bank_raddr),
		.bank_rdata(bank_rdata),
		.req(req_if.rx)
	);

	ps_reqhandler #(
		.MEM_DEPTH(MEM_DEPTH),
		.REQ_BUFFER_SZ(REQ_BUFFER_SZ)
	) u_handler (
		.clk(clk),
		.rst(rst),
		.transmit_wrsp_rdy(bready),
		.transmit_rdata_rdy(rready),
		.wresp(bresp),
		.transmit_wresp(bvalid),
		.transmit_rdata(rvalid),
		.rdata_out(rdata),
		.req(req_if.hd),
		.mem(mem_if.hd)
	);

	ps_reg_bank #(
		.MEM_DEPTH(MEM_DEPTH)
	) u_bank (
		.clk(clk),
		.rst(rst),
		.raddr(bank_raddr),
		.rdata(bank_rdata),
		.mem(mem_if.bank)
	);
endmodule

// ==== source/ps_mem_if.sv ====
`timescale 1ns/100ps

interface ps_mem_if;
	import ps_axi_pkg::*;

	logic write_req; // Level held until wcomplete
	index_t windex;
	data_t wdata;

	logic read_req; // Level held until rcomplete
	index_t rindex;

	// One-cycle completion pulses from the bank
	logic wcomplete;
	logic rcomplete;

	modport hd (
		output write_req, windex, wdata, read_req, rindex,
		input wcomplete, rcomplete
	);

	modport bank (
		input write_req, windex, wdata, read_req, rindex,
		output wcomplete, rcomplete
	);
endinterface

// ==== source/ps_reg_bank.sv ====
`timescale 1ns/100ps

module ps_reg_bank #(
	parameter int MEM_DEPTH = 64
) (
	input logic clk,
	input logic rst,
	input ps_axi_pkg::index_t raddr,
	output ps_axi_pkg::data_t rdata,
	ps_mem_if.bank mem
);
	import ps_axi_pkg::*;

	localparam int ROW_W = $clog2(MEM_DEPTH);

	data_t regs [MEM_DEPTH];
	logic w_pending;

	assign w_pending = mem.write_req && !mem.wcomplete;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < MEM_DEPTH; i++) begin
				regs[i] <= '0;
			end
			mem.wcomplete <= 1'b0;
			mem.rcomplete <= 1'b0;
		end else begin
			mem.wcomplete <= w_pending;
			// A read slot only goes out when no write is waiting
			mem.rcomplete <= mem.read_req && !mem.rcomplete && !w_pending;
			if (mem.wcomplete && mem.windex < MEM_DEPTH) begin
				regs[mem.windex[ROW_W-1:0]] <= mem.wdata; // Out-of-range writes dropped
			end
		end
	end

	// Read port with the range checked in the receiver
	always_ff @(posedge clk) begin
		rdata <= regs[raddr[ROW_W-1:0]];
	end

	a_one_completion: assert property (@(posedge clk) disable iff (rst)
		!(mem.wcomplete && mem.rcomplete));
endmodule

// ==== source/ps_req_if.sv ====
`timescale 1ns/100ps

interface ps_req_if;
	import ps_axi_pkg::*;

	// Write index and data arrive as separate strobes
	logic have_windex;
	index_t windex;
	logic have_wdata;
	data_t wdata;

	// Read side carries the bank word along with its index
	logic have_rdata;
	index_t rindex;
	data_t rdata;

	modport rx (
		output have_windex, windex, have_wdata, wdata,
		output have_rdata, rindex, rdata
	);

	modport hd (
		input have_windex, windex, have_wdata, wdata,
		input have_rdata, rindex, rdata
	);
endinterface

// ==== source/ps_reqhandler.sv ====
`timescale 1ns/100ps

module ps_reqhandler #(
	parameter int MEM_DEPTH = 64,
	parameter int REQ_BUFFER_SZ = 4
) (
	input logic clk,
	input logic rst,
	input logic transmit_wrsp_rdy,
	input logic transmit_rdata_rdy,
	output ps_axi_pkg::resp_t wresp,
	output logic transmit_wresp,
	output logic transmit_rdata,
	output ps_axi_pkg::data_t rdata_out,
	ps_req_if.hd req,
	ps_mem_if.hd mem
);
	import ps_axi_pkg::*;

	typedef logic [$clog2(REQ_BUFFER_SZ):0] ptr_t;
	typedef logic [$clog2(REQ_BUFFER_SZ)-1:0] sel_t;
	typedef enum logic [1:0] {IDLE, REQUEST, SEND} rsp_state_t;

	rsp_state_t w_state, r_state;
	ptr_t wi_ptr, wd_ptr, rd_ptr; // Entry counts with the top at ptr-1
	sel_t w_sel, r_sel;           // Entry being served
	index_t wi_buf [REQ_BUFFER_SZ];
	data_t wd_buf [REQ_BUFFER_SZ];
	index_t ri_buf [REQ_BUFFER_SZ];
	data_t rd_buf [REQ_BUFFER_SZ];
	logic wi_push, wd_push, rd_push;
	logic w_pop, r_pop;

	assign w_pop = (w_state == REQUEST) && mem.wcomplete;
	assign r_pop = (r_state == SEND) && transmit_rdata_rdy;

	// A full stack still takes a push when an entry leaves in the same cycle
	assign wi_push = req.have_windex && (wi_ptr < REQ_BUFFER_SZ || w_pop);
	assign wd_push = req.have_wdata && (wd_ptr < REQ_BUFFER_SZ || w_pop);
	assign rd_push = req.have_rdata && (rd_ptr < REQ_BUFFER_SZ || r_pop);

	always_comb begin
		mem.write_req = (w_state == REQUEST) && !mem.wcomplete;
		mem.windex = wi_buf[w_sel];
		mem.wdata = wd_buf[w_sel];
		mem.read_req = (r_state == REQUEST) && !mem.rcomplete;
		mem.rindex = ri_buf[r_sel];
		rdata_out = rd_buf[r_sel]; // Entries below the top never move while served
	end

	// A pop closes the gap above the served entry
	always_ff @(posedge clk) begin
		for (int i = 0; i < REQ_BUFFER_SZ - 1; i++) begin
			if (w_pop && i >= w_sel) begin
				wi_buf[i] <= wi_buf[i + 1];
				wd_buf[i] <= wd_buf[i + 1];
			end
			if (r_pop && i >= r_sel) begin
				ri_buf[i] <= ri_buf[i + 1];
				rd_buf[i] <= rd_buf[i + 1];
			end
		end
		if (wi_push) wi_buf[sel_t'(w_pop ? wi_ptr - 1'b1 : wi_ptr)] <= req.windex;
		if (wd_push) wd_buf[sel_t'(w_pop ? wd_ptr - 1'b1 : wd_ptr)] <= req.wdata;
		if (rd_push) begin
			ri_buf[sel_t'(r_pop ? rd_ptr - 1'b1 : rd_ptr)] <= req.rindex;
			rd_buf[sel_t'(r_pop ? rd_ptr - 1'b1 : rd_ptr)] <= req.rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wi_ptr <= '0;
			wd_ptr <= '0;
			rd_ptr <= '0;
			w_sel <= '0;
			r_sel <= '0;
			w_state <= IDLE;
			r_state <= IDLE;
			transmit_wresp <= 1'b0;
			transmit_rdata <= 1'b0;
			wresp <= OKAY;
		end else begin
			wi_ptr <= wi_ptr + ptr_t'(wi_push) - ptr_t'(w_pop);
			wd_ptr <= wd_ptr + ptr_t'(wd_push) - ptr_t'(w_pop);
			rd_ptr <= rd_ptr + ptr_t'(rd_push) - ptr_t'(r_pop);

			case (w_state)
				IDLE: begin
					// Wait for a complete index/data pair with nothing landing
					if (wd_ptr != 0 && wd_ptr == wi_ptr &&
						!req.have_windex && !req.have_wdata) begin
						w_sel <= sel_t'(wd_ptr - 1'b1);
						w_state <= REQUEST;
					end
				end
				REQUEST: begin
					if (mem.wcomplete) begin
						wresp <= (mem.windex < MEM_DEPTH) ? OKAY : SLVERR;
						transmit_wresp <= 1'b1;
						w_state <= SEND;
					end
				end
				SEND: begin
					if (transmit_wrsp_rdy) begin
						transmit_wresp <= 1'b0;
						w_state <= IDLE;
					end
				end
				default: w_state <= IDLE;
			endcase

			case (r_state)
				IDLE: begin
					if (rd_ptr != 0 && !req.have_rdata) begin
						r_sel <= sel_t'(rd_ptr - 1'b1); // Newest read goes first
						r_state <= REQUEST;
					end
				end
				REQUEST: begin
					if (mem.rcomplete) begin
						transmit_rdata <= 1'b1;
						r_state <= SEND;
					end
				end
				SEND: begin
					if (transmit_rdata_rdy) begin
						transmit_rdata <= 1'b0;
						r_state <= IDLE;
					end
				end
				default: r_state <= IDLE;
			endcase
		end
	end

	a_ptr_bound: assert property (@(posedge clk) disable iff (rst)
		wi_ptr <= REQ_BUFFER_SZ && wd_ptr <= REQ_BUFFER_SZ && rd_ptr <= REQ_BUFFER_SZ);

	// Responses hold steady under back-pressure
	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		transmit_wresp && !transmit_wrsp_rdy |=> transmit_wresp && $stable(wresp));
	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		transmit_rdata && !transmit_rdata_rdy |=> transmit_rdata && $stable(rdata_out));
endmodule

// ==== verif/tb_ps_axi.sv ====
`timescale 1ns/100ps

module tb_ps_axi;
	import ps_axi_pkg::*;

	localparam int MEM_DEPTH = 64;
	localparam int LIMIT = 200; // Cycles allowed for any one wait

	logic clk, rst;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	index_t awaddr, araddr, idx;
	data_t wdata, rdata;
	resp_t bresp, rresp;

	data_t ref_mem [MEM_DEPTH];
	resp_t exp_b_q [$]; // Expected responses in flight
	data_t exp_r_q [$];
	int b_count, seed, base;

	ps_axi_top #(.MEM_DEPTH(MEM_DEPTH), .REQ_BUFFER_SZ(4)) u_dut (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic resp_t exp_resp(index_t i);
		return (i < MEM_DEPTH) ? OKAY : SLVERR;
	endfunction

	function automatic data_t exp_rdata(index_t i);
		return (i < MEM_DEPTH) ? ref_mem[i[5:0]] : '0; // Unimplemented words read zero
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_resp(input string name, input resp_t got, input resp_t exp);
		if (got !== exp) stop_with_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) stop_with_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) stop_with_failure($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// Compares every B and R handshake against the queued expectations
	always @(posedge clk) begin
		if (!rst && bvalid && bready) begin
			if (exp_b_q.size() == 0) stop_with_failure("write response with no write outstanding");
			else check_resp("bresp", bresp, exp_b_q.pop_front());
			b_count++;
		end
		if (!rst && rvalid && rready) begin
			if (exp_r_q.size() == 0) stop_with_failure("read data with no read outstanding");
			else check_data("rdata", rdata, exp_r_q.pop_front());
			check_resp("rresp", rresp, OKAY);
		end
	end

	task automatic send_write(input index_t i, input data_t d);
		int n;
		logic aw_go, w_go;
		n = 0;
		awvalid = 1'b1;
		awaddr = i;
		wvalid = 1'b1;
		wdata = d;
		exp_b_q.push_back(exp_resp(i));
		if (i < MEM_DEPTH) ref_mem[i[5:0]] = d;
		while (awvalid || wvalid) begin
			if (n == LIMIT) stop_with_failure("write address or data was never accepted");
			n++;
			aw_go = awvalid && awready; // Readys only move on the rising edge
			w_go = wvalid && wready;
			@(negedge clk);
			if (aw_go) awvalid = 1'b0;
			if (w_go) wvalid = 1'b0;
		end
	endtask

	task automatic send_read(input index_t i);
		int n;
		logic ar_go;
		n = 0;
		arvalid = 1'b1;
		araddr = i;
		exp_r_q.push_back(exp_rdata(i));
		while (arvalid) begin
			if (n == LIMIT) stop_with_failure("read address was never accepted");
			n++;
			ar_go = arready;
			@(negedge clk);
			if (ar_go) arvalid = 1'b0;
		end
	endtask

	// Hold bready low for some cycles after bvalid shows up before accepting
	task automatic take_write_resp(input int hold);
		int n;
		resp_t held;
		n = 0;
		while (!bvalid) begin
			if (n == LIMIT) stop_with_failure("timed out waiting for a write response");
			n++;
			@(negedge clk);
		end
		held = bresp;
		repeat (hold) begin
			@(negedge clk);
			check_flag("bvalid", bvalid, 1'b1);
			check_resp("bresp", bresp, held);
		end
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic take_read_resp(input int hold);
		int n;
		data_t held;
		n = 0;
		while (!rvalid) begin
			if (n == LIMIT) stop_with_failure("timed out waiting for read data");
			n++;
			@(negedge clk);
		end
		held = rdata;
		repeat (hold) begin
			@(negedge clk);
			check_flag("rvalid", rvalid, 1'b1);
			check_data("rdata", rdata, held);
		end
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic wait_b_count(input int target);
		int n;
		n = 0;
		while (b_count < target) begin
			if (n == LIMIT) stop_with_failure("not all buffered write responses came back");
			n++;
			@(negedge clk);
		end
	endtask

	initial begin
		seed = 32'hedd1;
		rst = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		b_count = 0;
		for (int i = 0; i < MEM_DEPTH; i++) ref_mem[i] = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		check_flag("bvalid", bvalid, 1'b0);
		check_flag("rvalid", rvalid, 1'b0);
		check_flag("awready", awready, 1'b1);
		check_flag("wready", wready, 1'b1);
		check_flag("arready", arready, 1'b1);

		send_write(8'd5, 32'hcafe_0001); // Simple write then read back
		take_write_resp(0);
		send_read(8'd5);
		take_read_resp(0);

		send_write(8'd200, 32'hdead_beef); // Beyond the implemented words
		take_write_resp(0);
		send_read(8'd200);
		take_read_resp(0);

		for (int k = 0; k < 8; k++) begin
			idx = index_t'($random(seed)) & 8'h3f;
			send_write(idx, data_t'($random(seed)));
			take_write_resp(1 + ($random(seed) & 7));
			send_read(idx);
			take_read_resp(1 + ($random(seed) & 7));
		end

		// Four writes stack up behind a closed B channel
		base = b_count;
		for (int k = 0; k < 4; k++) send_write(index_t'(10 + 7 * k), data_t'($random(seed)));
		check_flag("awready", awready, 1'b0); // Outstanding limit reached
		check_flag("wready", wready, 1'b0);
		bready = 1'b1;
		wait_b_count(base + 4);
		bready = 1'b0;
		repeat (4) @(negedge clk);
		check_flag("bvalid", bvalid, 1'b0);
		for (int k = 0; k < 4; k++) begin
			send_read(index_t'(10 + 7 * k));
			take_read_resp(0);
		end

		for (int k = 0; k < 200; k++) begin
			idx = index_t'($random(seed));
			if (($random(seed) & 3) != 0) idx[7:6] = 2'b00; // Mostly in range
			if ($random(seed) & 1) begin
				send_write(idx, data_t'($random(seed)));
				take_write_resp(0);
			end else begin
				send_read(idx);
				take_read_resp(0);
			end
		end

		$display("*** PASSED ***");
		$finish;
	end
endmodule
